/* isaPkg.sv */
package isaPkg;

  // risc-v codes keep bit 4 clear
  typedef enum logic [4:0] {
    aluAdd   = 5'b00000,
    aluSub   = 5'b00001,
    aluAnd   = 5'b00010,
    aluOr    = 5'b00011,
    aluXor   = 5'b00100,
    aluSlt   = 5'b00101,
    aluPassB = 5'b00110, // lui and mov
    aluSll   = 5'b01000,
    aluSrl   = 5'b01001,
    aluSra   = 5'b01010,
    aluBic   = 5'b10000,
    aluAdc   = 5'b10010,
    aluSbc   = 5'b10011,
    aluRsb   = 5'b10100,
    aluRsc   = 5'b10110,
    aluMvn   = 5'b10111,
    aluPassA = 5'b11111  // forward operand 1
  } aluCtrlE;

  typedef enum logic [2:0] {
    immI     = 3'b000,
    immS     = 3'b001,
    immB     = 3'b010,
    immJ     = 3'b011,
    immRot   = 3'b100, // arm rotated imm8
    immImm12 = 3'b101, // arm load/store offset
    immBr24  = 3'b110, // arm branch
    immU     = 3'b111
  } immTypeE;

  // arm encodings, risc-v branches reuse them
  typedef enum logic [3:0] {
    condEq = 4'b0000,
    condNe = 4'b0001,
    condHs = 4'b0010,
    condLo = 4'b0011,
    condMi = 4'b0100,
    condPl = 4'b0101,
    condVs = 4'b0110,
    condVc = 4'b0111,
    condHi = 4'b1000,
    condLs = 4'b1001,
    condGe = 4'b1010,
    condLt = 4'b1011,
    condGt = 4'b1100,
    condLe = 4'b1101,
    condAl = 4'b1110,
    condNv = 4'b1111
  } condE;

  typedef enum logic [1:0] {resAlu = 2'b00, resMem = 2'b01, resPc4 = 2'b10} resultSrcE;

  typedef enum logic {isaRv = 1'b0, isaArm = 1'b1} isaE;

  typedef enum logic [1:0] {ldmFirst = 2'b00, ldmRest = 2'b01} ldmStepE;

  typedef enum logic [1:0] {memByte = 2'b00, memHalf = 2'b01, memWord = 2'b10} memSizeE;

endpackage

/* rvDecoder.sv */
module rvDecoder
  import isaPkg::*;
(
  input  logic [31:0] instr,
  output logic        regWrite,
  output logic        memWrite,
  output memSizeE     memSize,
  output logic        memSigned,
  output aluCtrlE     aluControl,
  output logic [1:0]  branch,    // bit 0 conditional, bit 1 jump
  output logic [1:0]  aluSrc,    // bit 1 puts pc on operand a
  output immTypeE     immType,
  output resultSrcE   resultSrc,
  output condE        cond,
  output logic        rvValid
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  aluCtrlE    aluArith; // R-type and I-type operation

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  // sub exists only in R-type, so opcode bit 5 qualifies it
  always_comb begin
    case (funct3)
      3'b000:  aluArith = (funct7b5 && opcode[5]) ? aluSub : aluAdd;
      3'b001:  aluArith = aluSll;
      3'b010,
      3'b011:  aluArith = aluSlt; // sltu shares the slt code
      3'b100:  aluArith = aluXor;
      3'b101:  aluArith = funct7b5 ? aluSra : aluSrl;
      3'b110:  aluArith = aluOr;
      default: aluArith = aluAnd;
    endcase
  end

  always_comb begin
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    memSize    = memWord;
    memSigned  = 1'b0;
    aluControl = aluAdd;
    branch     = 2'b00;
    aluSrc     = 2'b00;
    immType    = immI;
    resultSrc  = resAlu;
    rvValid    = 1'b1;
    case (opcode)
      7'b0000011: begin // load
        regWrite  = 1'b1;
        aluSrc    = 2'b01;
        resultSrc = resMem;
        memSigned = ~funct3[2] & ~funct3[1]; // lb, lh
        case (funct3)
          3'b000, 3'b100: memSize = memByte;
          3'b001, 3'b101: memSize = memHalf;
          3'b010:         memSize = memWord;
          default:        rvValid = 1'b0;
        endcase
      end
      7'b0100011: begin // store
        memWrite = 1'b1;
        aluSrc   = 2'b01;
        immType  = immS;
        case (funct3)
          3'b000:  memSize = memByte;
          3'b001:  memSize = memHalf;
          3'b010:  memSize = memWord;
          default: rvValid = 1'b0;
        endcase
      end
      7'b0110011: begin // R-type
        regWrite   = 1'b1;
        aluControl = aluArith;
      end
      7'b0010011: begin // I-type alu
        regWrite   = 1'b1;
        aluSrc     = 2'b01;
        aluControl = aluArith;
      end
      7'b1100011: begin // conditional branch, compare by subtract
        branch     = 2'b01;
        immType    = immB;
        aluControl = aluSub;
        rvValid    = (funct3[2:1] != 2'b01);
      end
      7'b1101111: begin // jal
        regWrite  = 1'b1;
        branch    = 2'b10;
        aluSrc    = 2'b10;
        immType   = immJ;
        resultSrc = resPc4;
      end
      7'b1100111: begin // jalr
        regWrite  = 1'b1;
        branch    = 2'b10;
        aluSrc    = 2'b01;
        resultSrc = resPc4;
      end
      7'b0110111: begin // lui
        regWrite   = 1'b1;
        aluSrc     = 2'b01;
        immType    = immU;
        aluControl = aluPassB;
      end
      7'b0010111: begin // auipc
        regWrite = 1'b1;
        aluSrc   = 2'b11;
        immType  = immU;
      end
      default: rvValid = 1'b0;
    endcase
  end

  always_comb begin
    cond = condAl; // non-branch always executes
    if (opcode == 7'b1100011) begin
      case (funct3)
        3'b000:  cond = condEq;
        3'b001:  cond = condNe;
        3'b100:  cond = condLt;
        3'b101:  cond = condGe;
        3'b110:  cond = condLo; // bltu
        3'b111:  cond = condHs; // bgeu
        default: cond = condAl;
      endcase
    end
  end

endmodule

/* armDecoder.sv */
module armDecoder
  import isaPkg::*;
(
  input  logic [31:0] instr,
  input  ldmStepE     ldmStep,
  input  logic        ldmStall,
  output logic        regWrite,
  output logic        memWrite,
  output logic        memToReg,
  output logic        aluSrc,
  output logic        branch,
  output immTypeE     immType,
  output logic [3:0]  regSrc,
  output aluCtrlE     aluControl,
  output logic [1:0]  flagWrite,  // bit 1 nz, bit 0 cv
  output logic [4:0]  shiftAmt,
  output logic [2:0]  shiftType,
  output logic        pcSrc,
  output logic        armStallF,
  output ldmStepE     ldmNext,
  output logic [1:0]  fwd,
  output logic        armValid
);

  logic [2:0] op;
  logic [3:0] dpOp;
  logic [3:0] rd;
  logic       sBit;
  logic       isCompare;
  logic       postIdx;
  aluCtrlE    dpAlu;
  aluCtrlE    addSub;  // direction from the U bit
  aluCtrlE    ldmAlu;

  assign op        = instr[27:25];
  assign dpOp      = instr[24:21];
  assign rd        = instr[15:12];
  assign sBit      = instr[20];
  assign isCompare = (dpOp[3:2] == 2'b10); // tst, teq, cmp, cmn
  assign postIdx   = ~instr[24];
  assign addSub    = instr[23] ? aluAdd : aluSub;

  always_comb begin
    case (dpOp)
      4'b0000: dpAlu = aluAnd;
      4'b0001: dpAlu = aluXor;
      4'b0010: dpAlu = aluSub;
      4'b0011: dpAlu = aluRsb;
      4'b0100: dpAlu = aluAdd;
      4'b0101: dpAlu = aluAdc;
      4'b0110: dpAlu = aluSbc;
      4'b0111: dpAlu = aluRsc;
      4'b1000: dpAlu = aluAnd; // tst
      4'b1001: dpAlu = aluXor; // teq
      4'b1010: dpAlu = aluSub; // cmp
      4'b1011: dpAlu = aluAdd; // cmn
      4'b1100: dpAlu = aluOr;
      4'b1101: dpAlu = aluPassB;
      4'b1110: dpAlu = aluBic;
      default: dpAlu = aluMvn;
    endcase
  end

  // base register update order depends on pre or post indexing
  always_comb begin
    if (ldmStep == ldmFirst) begin
      ldmAlu = postIdx ? aluPassA : addSub;
    end else if (ldmStall) begin
      ldmAlu = addSub;
    end else begin
      ldmAlu = postIdx ? addSub : aluPassA;
    end
  end

  always_comb begin
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    memToReg   = 1'b0;
    aluSrc     = 1'b0;
    branch     = 1'b0;
    immType    = immRot;
    regSrc     = 4'b0000;
    aluControl = aluAdd;
    flagWrite  = 2'b00;
    shiftAmt   = 5'd0;
    shiftType  = 3'b100; // lsl, no shift with amount 0
    armStallF  = 1'b0;
    ldmNext    = ldmFirst;
    fwd        = 2'b00;
    armValid   = 1'b1;
    casez (op)
      3'b00?: begin // data processing
        regWrite   = ~isCompare;
        aluSrc     = op[0];
        aluControl = dpAlu;
        flagWrite  = {sBit, sBit & (dpAlu == aluAdd || dpAlu == aluSub)};
        if (!op[0]) begin
          shiftAmt  = instr[11:7];
          shiftType = {1'b1, instr[6:5]};
        end
      end
      3'b010: begin // ldr, str with immediate offset
        aluSrc     = 1'b1;
        immType    = immImm12;
        aluControl = addSub;
        regWrite   = instr[20];
        memToReg   = instr[20];
        memWrite   = ~instr[20];
        regSrc     = instr[20] ? 4'b0000 : 4'b0010;
      end
      3'b101: begin // b
        branch  = 1'b1;
        aluSrc  = 1'b1;
        immType = immBr24;
        regSrc  = 4'b0001;
      end
      3'b100: begin // ldm, one transfer per cycle
        aluSrc     = 1'b1;
        immType    = immImm12; // step offset is generated after decode
        aluControl = ldmAlu;
        if (ldmStep == ldmFirst || ldmStall) begin
          regSrc    = 4'b0100;
          memToReg  = 1'b1;
          regWrite  = instr[20];
          memWrite  = ~instr[20];
          armStallF = 1'b1;
          ldmNext   = ldmRest;
          fwd       = (ldmStep == ldmFirst) ? 2'b00 : 2'b01;
        end else begin
          regSrc   = 4'b1000;
          regWrite = instr[21]; // base write-back
          fwd      = 2'b01;
        end
      end
      default: armValid = 1'b0;
    endcase
  end

  assign pcSrc = regWrite & (rd == 4'hf);

  always_comb
    assert final (op == 3'b100 || ldmNext == ldmFirst)
      else $error("ldmNext left first outside an LDM");

endmodule

/* immExtend.sv */
module immExtend
  import isaPkg::*;
(
  input  logic [31:0] instr,
  input  immTypeE     immType,
  output logic [31:0] immExt
);

  logic [4:0]  rot;
  logic [31:0] imm8;
  logic [63:0] rotPair; // doubled word turns the shift into a rotate

  assign rot     = {instr[11:8], 1'b0};
  assign imm8    = {24'd0, instr[7:0]};
  assign rotPair = {imm8, imm8} >> rot;

  always_comb begin
    case (immType)
      immI:     immExt = {{20{instr[31]}}, instr[31:20]};
      immS:     immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      immB: begin
        immExt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
      end
      immJ: begin
        immExt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};
      end
      immU:     immExt = {instr[31:12], 12'd0};
      immRot:   immExt = rotPair[31:0];
      immImm12: immExt = {20'd0, instr[11:0]};
      immBr24:  immExt = {{6{instr[23]}}, instr[23:0], 2'b00}; // word offset
      default:  immExt = 32'd0;
    endcase
  end

endmodule

/* decodeControl.sv */
module decodeControl
  import isaPkg::*;
#(
  parameter isaE ResetIsa = isaRv
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instr,
  input  logic        notFlushed,
  input  logic        flushE,
  input  logic        rvRegWrite,
  input  logic        rvMemWrite,
  input  memSizeE     rvMemSize,
  input  logic        rvMemSigned,
  input  aluCtrlE     rvAluControl,
  input  logic [1:0]  rvBranch,
  input  logic [1:0]  rvAluSrc,
  input  immTypeE     rvImmType,
  input  resultSrcE   rvResultSrc,
  input  condE        rvCond,
  input  logic        rvValid,
  input  logic        armRegWrite,
  input  logic        armMemWrite,
  input  logic        armMemToReg,
  input  logic        armAluSrc,
  input  logic        armBranch,
  input  immTypeE     armImmType,
  input  logic [3:0]  armRegSrc,
  input  aluCtrlE     armAluControl,
  input  logic [1:0]  armFlagWrite,
  input  logic [4:0]  armShiftAmt,
  input  logic [2:0]  armShiftType,
  input  logic        armPcSrc,
  input  logic [1:0]  armFwd,
  input  logic        armValid,
  input  logic        armStallF,
  input  ldmStepE     ldmNext,
  output logic        regWrite,
  output logic        memWrite,
  output memSizeE     memSize,
  output logic        memSigned,
  output aluCtrlE     aluControl,
  output logic [1:0]  branch,
  output logic [1:0]  aluSrc,
  output immTypeE     immType,
  output condE        cond,
  output resultSrcE   resultSrc,
  output logic        pcSrc,
  output logic [1:0]  flagWrite,
  output logic [3:0]  regSrc,
  output logic [4:0]  shiftAmt,
  output logic [2:0]  shiftType,
  output logic        stallF,
  output logic [1:0]  fwd,
  output logic        isArm,
  output logic        illegal,
  output ldmStepE     ldmStep
);

  isaE mode;   // set in use by the previous word
  isaE isaSel; // decision for the current word

  // a word only one decoder accepts picks the set, anything else keeps it
  always_comb begin
    isaSel = mode;
    if (notFlushed && (rvValid != armValid)) begin
      isaSel = armValid ? isaArm : isaRv;
    end
  end

  assign isArm   = (isaSel == isaArm);
  assign illegal = notFlushed & ~rvValid & ~armValid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mode    <= ResetIsa;
      ldmStep <= ldmFirst;
    end else begin
      mode <= isaSel;
      if (!flushE) begin
        ldmStep <= isArm ? ldmNext : ldmFirst;
      end
    end
  end

  always_comb begin
    if (isArm) begin
      regWrite   = armRegWrite;
      memWrite   = armMemWrite;
      memSize    = memWord; // arm subset moves words only
      memSigned  = 1'b0;
      aluControl = armAluControl;
      branch     = {armBranch, 1'b0};
      aluSrc     = {1'b0, armAluSrc};
      immType    = armImmType;
      cond       = condE'(instr[31:28]);
      resultSrc  = armMemToReg ? resMem : resAlu;
      pcSrc      = armPcSrc;
      flagWrite  = armFlagWrite;
      regSrc     = armRegSrc;
      shiftAmt   = armShiftAmt;
      shiftType  = armShiftType;
      stallF     = armStallF;
      fwd        = armFwd;
    end else begin
      regWrite   = rvRegWrite;
      memWrite   = rvMemWrite;
      memSize    = rvMemSize;
      memSigned  = rvMemSigned;
      aluControl = rvAluControl;
      branch     = rvBranch;
      aluSrc     = rvAluSrc;
      immType    = rvImmType;
      cond       = rvCond;
      resultSrc  = rvResultSrc;
      pcSrc      = 1'b0;   // arm-only outputs parked
      flagWrite  = 2'b00;
      regSrc     = 4'b0000;
      shiftAmt   = 5'd0;
      shiftType  = 3'b100; // lsl by zero
      stallF     = 1'b0;
      fwd        = 2'b00;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) !isArm |-> !stallF)
    else $error("fetch stall raised in RISC-V mode");

  assert property (@(posedge clk) disable iff (!rstN)
    illegal |-> (isArm == (mode == isaArm)))
    else $error("illegal word changed the instruction set");

endmodule

/* decodeStage.sv */
module decodeStage
  import isaPkg::*;
#(
  parameter isaE ResetIsa = isaRv
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instr,
  input  logic        notFlushed,
  input  logic        flushE,
  input  logic        ldmStall,
  output logic        regWrite,
  output logic        memWrite,
  output memSizeE     memSize,
  output logic        memSigned,
  output aluCtrlE     aluControl,
  output logic [1:0]  branch,
  output logic [1:0]  aluSrc,
  output immTypeE     immType,
  output logic [31:0] immExt,
  output condE        cond,
  output resultSrcE   resultSrc,
  output logic        pcSrc,
  output logic [1:0]  flagWrite,
  output logic [3:0]  regSrc,
  output logic [4:0]  shiftAmt,
  output logic [2:0]  shiftType,
  output logic        stallF,
  output logic [1:0]  fwd,
  output logic        isArm,
  output logic        illegal
);

  logic       rvRegWrite;
  logic       rvMemWrite;
  memSizeE    rvMemSize;
  logic       rvMemSigned;
  aluCtrlE    rvAluControl;
  logic [1:0] rvBranch;
  logic [1:0] rvAluSrc;
  immTypeE    rvImmType;
  resultSrcE  rvResultSrc;
  condE       rvCond;
  logic       rvValid;
  logic       armRegWrite;
  logic       armMemWrite;
  logic       armMemToReg;
  logic       armAluSrc;
  logic       armBranch;
  immTypeE    armImmType;
  logic [3:0] armRegSrc;
  aluCtrlE    armAluControl;
  logic [1:0] armFlagWrite;
  logic [4:0] armShiftAmt;
  logic [2:0] armShiftType;
  logic       armPcSrc;
  logic       armStallF;
  ldmStepE    ldmNext;
  ldmStepE    ldmStep;
  logic [1:0] armFwd;
  logic       armValid;

  rvDecoder rvDecoder_inst (
    .instr(instr),
    .regWrite(rvRegWrite),
    .memWrite(rvMemWrite),
    .memSize(rvMemSize),
    .memSigned(rvMemSigned),
    .aluControl(rvAluControl),
    .branch(rvBranch),
    .aluSrc(rvAluSrc),
    .immType(rvImmType),
    .resultSrc(rvResultSrc),
    .cond(rvCond),
    .rvValid(rvValid)
  );

  armDecoder armDecoder_inst (
    .instr(instr),
    .ldmStep(ldmStep),
    .ldmStall(ldmStall),
    .regWrite(armRegWrite),
    .memWrite(armMemWrite),
    .memToReg(armMemToReg),
    .aluSrc(armAluSrc),
    .branch(armBranch),
    .immType(armImmType),
    .regSrc(armRegSrc),
    .aluControl(armAluControl),
    .flagWrite(armFlagWrite),
    .shiftAmt(armShiftAmt),
    .shiftType(armShiftType),
    .pcSrc(armPcSrc),
    .armStallF(armStallF),
    .ldmNext(ldmNext),
    .fwd(armFwd),
    .armValid(armValid)
  );

  immExtend immExtend_inst (
    .instr(instr),
    .immType(immType),
    .immExt(immExt)
  );

  decodeControl #(.ResetIsa(ResetIsa)) decodeControl_inst (
    .clk(clk),
    .rstN(rstN),
    .instr(instr),
    .notFlushed(notFlushed),
    .flushE(flushE),
    .rvRegWrite(rvRegWrite),
    .rvMemWrite(rvMemWrite),
    .rvMemSize(rvMemSize),
    .rvMemSigned(rvMemSigned),
    .rvAluControl(rvAluControl),
    .rvBranch(rvBranch),
    .rvAluSrc(rvAluSrc),
    .rvImmType(rvImmType),
    .rvResultSrc(rvResultSrc),
    .rvCond(rvCond),
    .rvValid(rvValid),
    .armRegWrite(armRegWrite),
    .armMemWrite(armMemWrite),
    .armMemToReg(armMemToReg),
    .armAluSrc(armAluSrc),
    .armBranch(armBranch),
    .armImmType(armImmType),
    .armRegSrc(armRegSrc),
    .armAluControl(armAluControl),
    .armFlagWrite(armFlagWrite),
    .armShiftAmt(armShiftAmt),
    .armShiftType(armShiftType),
    .armPcSrc(armPcSrc),
    .armFwd(armFwd),
    .armValid(armValid),
    .armStallF(armStallF),
    .ldmNext(ldmNext),
    .regWrite(regWrite),
    .memWrite(memWrite),
    .memSize(memSize),
    .memSigned(memSigned),
    .aluControl(aluControl),
    .branch(branch),
    .aluSrc(aluSrc),
    .immType(immType),
    .cond(cond),
    .resultSrc(resultSrc),
    .pcSrc(pcSrc),
    .flagWrite(flagWrite),
    .regSrc(regSrc),
    .shiftAmt(shiftAmt),
    .shiftType(shiftType),
    .stallF(stallF),
    .fwd(fwd),
    .isArm(isArm),
    .illegal(illegal),
    .ldmStep(ldmStep)
  );

endmodule

/* tbDecodeStage.sv */
module tbDecodeStage
  import isaPkg::*;
();

  localparam int CycleLimit = 400; // roughly twice the directed run

  logic        clk = 1'b0;
  logic        rstN;
  logic [31:0] instr;
  logic        notFlushed;
  logic        flushE;
  logic        ldmStall;
  logic        regWrite;
  logic        memWrite;
  memSizeE     memSize;
  logic        memSigned;
  aluCtrlE     aluControl;
  logic [1:0]  branch;
  logic [1:0]  aluSrc;
  immTypeE     immType;
  logic [31:0] immExt;
  condE        cond;
  resultSrcE   resultSrc;
  logic        pcSrc;
  logic [1:0]  flagWrite;
  logic [3:0]  regSrc;
  logic [4:0]  shiftAmt;
  logic [2:0]  shiftType;
  logic        stallF;
  logic [1:0]  fwd;
  logic        isArm;
  logic        illegal;
  integer      seed = 32'h9d4a;
  int          cycleCount = 0;

  decodeStage #(.ResetIsa(isaRv)) decodeStage_inst (
    .clk(clk), .rstN(rstN), .instr(instr), .notFlushed(notFlushed),
    .flushE(flushE), .ldmStall(ldmStall), .regWrite(regWrite),
    .memWrite(memWrite), .memSize(memSize), .memSigned(memSigned),
    .aluControl(aluControl), .branch(branch), .aluSrc(aluSrc),
    .immType(immType), .immExt(immExt), .cond(cond), .resultSrc(resultSrc),
    .pcSrc(pcSrc), .flagWrite(flagWrite), .regSrc(regSrc),
    .shiftAmt(shiftAmt), .shiftType(shiftType), .stallF(stallF), .fwd(fwd),
    .isArm(isArm), .illegal(illegal)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic failCheck(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expectVal(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else failCheck($sformatf("%s is %0h, expected %0h, instr %08h", what, got, exp, instr));
  endtask

  // new word on the falling edge, outputs settle well before the rising edge
  task automatic drive(input logic [31:0] w, input logic nf, input logic stall,
                       input logic flush);
    @(negedge clk);
    instr      = w;
    notFlushed = nf;
    ldmStall   = stall;
    flushE     = flush;
    #20;
  endtask

  function automatic logic [31:0] signExtend(input logic [31:0] v, input int width);
    logic [31:0] r;
    r = v;
    for (int i = width; i < 32; i++) begin
      r[i] = v[width - 1];
    end
    return r;
  endfunction

  function automatic logic [31:0] rotateRight(input logic [31:0] v, input int n);
    logic [31:0] r;
    r = v;
    for (int i = 0; i < n; i++) begin
      r = {r[0], r[31:1]};
    end
    return r;
  endfunction

  // arm data-processing opcode table
  function automatic aluCtrlE armAluFor(input logic [3:0] dpOp);
    case (dpOp)
      4'd0, 4'd8:  return aluAnd; // and, tst
      4'd1, 4'd9:  return aluXor; // eor, teq
      4'd2, 4'd10: return aluSub; // sub, cmp
      4'd3:        return aluRsb;
      4'd4, 4'd11: return aluAdd; // add, cmn
      4'd5:        return aluAdc;
      4'd6:        return aluSbc;
      4'd7:        return aluRsc;
      4'd12:       return aluOr;
      4'd13:       return aluPassB; // mov
      4'd14:       return aluBic;
      default:     return aluMvn;
    endcase
  endfunction

  task automatic rvAluCase(input logic isR, input logic [2:0] f3, input logic b30,
                           input aluCtrlE exp);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [31:0] w;
    rd  = 5'($random(seed));
    rs1 = 5'($random(seed));
    rs2 = 5'($random(seed));
    imm = 12'($random(seed));
    if (isR) begin
      w = {1'b0, b30, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
    end else begin
      if (f3 == 3'b001 || f3 == 3'b101) imm[11:5] = {1'b0, b30, 5'd0}; // shamt form
      else imm[10] = b30;
      w = {imm, rs1, f3, rd, 7'b0010011};
    end
    drive(w, 1'b1, 1'b0, 1'b0);
    expectVal("aluControl", aluControl, exp);
    expectVal("regWrite", regWrite, 1'b1);
    expectVal("aluSrc", aluSrc, isR ? 2'b00 : 2'b01);
    expectVal("resultSrc", resultSrc, resAlu);
    expectVal("isArm", isArm, 1'b0);
    expectVal("illegal", illegal, 1'b0);
    if (!isR) begin
      expectVal("immType", immType, immI);
      expectVal("immExt", immExt, signExtend({20'd0, imm}, 12));
    end
  endtask

  task automatic rvAluWords();
    rvAluCase(1'b1, 3'b000, 1'b0, aluAdd);
    rvAluCase(1'b1, 3'b000, 1'b1, aluSub);
    rvAluCase(1'b1, 3'b001, 1'b0, aluSll);
    rvAluCase(1'b1, 3'b010, 1'b0, aluSlt);
    rvAluCase(1'b1, 3'b011, 1'b0, aluSlt); // sltu shares the code
    rvAluCase(1'b1, 3'b100, 1'b0, aluXor);
    rvAluCase(1'b1, 3'b101, 1'b0, aluSrl);
    rvAluCase(1'b1, 3'b101, 1'b1, aluSra);
    rvAluCase(1'b1, 3'b110, 1'b0, aluOr);
    rvAluCase(1'b1, 3'b111, 1'b0, aluAnd);
    rvAluCase(1'b0, 3'b000, 1'b0, aluAdd);
    rvAluCase(1'b0, 3'b000, 1'b1, aluAdd); // no subi
    rvAluCase(1'b0, 3'b001, 1'b0, aluSll);
    rvAluCase(1'b0, 3'b010, 1'b0, aluSlt);
    rvAluCase(1'b0, 3'b011, 1'b0, aluSlt);
    rvAluCase(1'b0, 3'b100, 1'b0, aluXor);
    rvAluCase(1'b0, 3'b101, 1'b0, aluSrl);
    rvAluCase(1'b0, 3'b101, 1'b1, aluSra);
    rvAluCase(1'b0, 3'b110, 1'b0, aluOr);
    rvAluCase(1'b0, 3'b111, 1'b0, aluAnd);
  endtask

  task automatic rvLoadCase(input logic [2:0] f3, input memSizeE expSize,
                            input logic expSigned);
    logic [11:0] imm;
    imm = 12'($random(seed));
    drive({imm, 5'($random(seed)), f3, 5'($random(seed)), 7'b0000011}, 1'b1, 1'b0, 1'b0);
    expectVal("memSize", memSize, expSize);
    expectVal("memSigned", memSigned, expSigned);
    expectVal("memWrite", memWrite, 1'b0);
    expectVal("regWrite", regWrite, 1'b1);
    expectVal("resultSrc", resultSrc, resMem);
    expectVal("immExt", immExt, signExtend({20'd0, imm}, 12));
    expectVal("illegal", illegal, 1'b0);
  endtask

  task automatic rvStoreCase(input logic [2:0] f3, input memSizeE expSize);
    logic [11:0] imm;
    imm = 12'($random(seed));
    drive({imm[11:5], 5'($random(seed)), 5'($random(seed)), f3, imm[4:0], 7'b0100011},
          1'b1, 1'b0, 1'b0);
    expectVal("memSize", memSize, expSize);
    expectVal("memWrite", memWrite, 1'b1);
    expectVal("regWrite", regWrite, 1'b0);
    expectVal("immType", immType, immS);
    expectVal("immExt", immExt, signExtend({20'd0, imm}, 12));
  endtask

  task automatic rvBranchCase(input logic [2:0] f3, input condE expCond);
    logic [12:0] imm;
    imm    = 13'($random(seed));
    imm[0] = 1'b0;
    drive({imm[12], imm[10:5], 5'($random(seed)), 5'($random(seed)), f3, imm[4:1],
           imm[11], 7'b1100011}, 1'b1, 1'b0, 1'b0);
    expectVal("branch", branch, 2'b01);
    expectVal("cond", cond, expCond);
    expectVal("regWrite", regWrite, 1'b0);
    expectVal("memWrite", memWrite, 1'b0);
    expectVal("immType", immType, immB);
    expectVal("immExt", immExt, signExtend({19'd0, imm}, 13));
  endtask

  task automatic rvJumpAndUpper();
    logic [20:0] jImm;
    logic [11:0] iImm;
    logic [19:0] uImm;
    jImm    = 21'($random(seed));
    jImm[0] = 1'b0;
    drive({jImm[20], jImm[10:1], jImm[11], jImm[19:12], 5'd1, 7'b1101111},
          1'b1, 1'b0, 1'b0); // jal
    expectVal("branch", branch, 2'b10);
    expectVal("resultSrc", resultSrc, resPc4);
    expectVal("regWrite", regWrite, 1'b1);
    expectVal("immType", immType, immJ);
    expectVal("immExt", immExt, signExtend({11'd0, jImm}, 21));
    iImm = 12'($random(seed));
    drive({iImm, 5'($random(seed)), 3'b000, 5'd1, 7'b1100111}, 1'b1, 1'b0, 1'b0); // jalr
    expectVal("branch", branch, 2'b10);
    expectVal("resultSrc", resultSrc, resPc4);
    expectVal("aluSrc", aluSrc, 2'b01);
    expectVal("immExt", immExt, signExtend({20'd0, iImm}, 12));
    uImm = 20'($random(seed));
    drive({uImm, 5'($random(seed)), 7'b0110111}, 1'b1, 1'b0, 1'b0); // lui
    expectVal("aluControl", aluControl, aluPassB);
    expectVal("regWrite", regWrite, 1'b1);
    expectVal("immType", immType, immU);
    expectVal("immExt", immExt, {uImm, 12'd0});
    uImm = 20'($random(seed));
    drive({uImm, 5'($random(seed)), 7'b0010111}, 1'b1, 1'b0, 1'b0); // auipc
    expectVal("aluSrc", aluSrc, 2'b11);
    expectVal("aluControl", aluControl, aluAdd);
    expectVal("immExt", immExt, {uImm, 12'd0});
  endtask

  task automatic rvMemAndFlow();
    rvLoadCase(3'b000, memByte, 1'b1);
    rvLoadCase(3'b001, memHalf, 1'b1);
    rvLoadCase(3'b010, memWord, 1'b0);
    rvLoadCase(3'b100, memByte, 1'b0);
    rvLoadCase(3'b101, memHalf, 1'b0);
    rvStoreCase(3'b000, memByte);
    rvStoreCase(3'b001, memHalf);
    rvStoreCase(3'b010, memWord);
    rvBranchCase(3'b000, condEq);
    rvBranchCase(3'b001, condNe);
    rvBranchCase(3'b100, condLt);
    rvBranchCase(3'b101, condGe);
    rvBranchCase(3'b110, condLo);
    rvBranchCase(3'b111, condHs);
    rvJumpAndUpper();
  endtask

  // 0xe2821010 arm only, 0x00500093 both, 0x0e000093 risc-v only, 0x0e000000 neither
  task automatic isaSelection();
    drive(32'hE2821010, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b1);
    expectVal("illegal", illegal, 1'b0);
    drive(32'h00500093, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b1);
    drive(32'h0E000093, 1'b0, 1'b0, 1'b0); // flushed slot
    expectVal("isArm", isArm, 1'b1);
    drive(32'h00500093, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b1);
    drive(32'h0E000000, 1'b1, 1'b0, 1'b0);
    expectVal("illegal", illegal, 1'b1);
    expectVal("isArm", isArm, 1'b1);
    drive(32'h0E000000, 1'b0, 1'b0, 1'b0);
    expectVal("illegal", illegal, 1'b0);
    drive(32'h00500093, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b1);
    drive(32'h0E000093, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b0);
    drive(32'h00500093, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b0);
  endtask

  task automatic armDpCase(input logic [3:0] dpOp, input logic sBit, input logic immForm);
    logic [3:0]  cnd;
    logic [3:0]  rd;
    logic [3:0]  rot;
    logic [4:0]  shamt;
    logic [1:0]  sh;
    logic [7:0]  imm8;
    logic        isCmp;
    logic        cv;
    logic [31:0] w;
    cnd   = 4'($random(seed));
    rd    = 4'($random(seed));
    rot   = 4'($random(seed));
    shamt = 5'($random(seed));
    sh    = 2'($random(seed));
    imm8  = 8'($random(seed));
    if (rd == 4'hf) rd = 4'he; // r15 is covered on its own
    if (immForm) w = {cnd, 3'b001, dpOp, sBit, 4'($random(seed)), rd, rot, imm8};
    else w = {cnd, 3'b000, dpOp, sBit, 4'($random(seed)), rd, shamt, sh, 1'b0,
              4'($random(seed))};
    isCmp = (dpOp >= 4'd8) && (dpOp <= 4'd11);
    cv    = sBit && (dpOp == 4'd2 || dpOp == 4'd4 || dpOp == 4'd10 || dpOp == 4'd11);
    drive(w, 1'b1, 1'b0, 1'b0);
    expectVal("isArm", isArm, 1'b1);
    expectVal("illegal", illegal, 1'b0);
    expectVal("aluControl", aluControl, armAluFor(dpOp));
    expectVal("flagWrite", flagWrite, {sBit, cv});
    expectVal("regWrite", regWrite, !isCmp);
    expectVal("cond", cond, cnd);
    expectVal("pcSrc", pcSrc, 1'b0);
    expectVal("regSrc", regSrc, 4'b0000);
    if (immForm) begin
      expectVal("aluSrc", aluSrc, 2'b01);
      expectVal("immType", immType, immRot);
      expectVal("immExt", immExt, rotateRight({24'd0, imm8}, 2 * rot));
      expectVal("shiftAmt", shiftAmt, 5'd0);
      expectVal("shiftType", shiftType, 3'b100);
    end else begin
      expectVal("aluSrc", aluSrc, 2'b00);
      expectVal("shiftAmt", shiftAmt, shamt);
      expectVal("shiftType", shiftType, {1'b1, sh});
    end
  endtask

  task automatic armDataProcessing();
    drive(32'hE2821010, 1'b1, 1'b0, 1'b0); // back to arm
    for (int op = 0; op < 16; op++) begin
      for (int s = 0; s < 2; s++) begin
        armDpCase(4'(op), 1'(s), 1'b0);
        armDpCase(4'(op), 1'(s), 1'b1);
      end
    end
    drive({4'hE, 3'b000, 4'b1101, 1'b0, 4'h0, 4'hF, 8'h00, 4'h3}, 1'b1, 1'b0, 1'b0);
    expectVal("pcSrc", pcSrc, 1'b1); // mov pc, r3
    drive({4'hE, 3'b000, 4'b1010, 1'b1, 4'h2, 4'hF, 8'h00, 4'h3}, 1'b1, 1'b0, 1'b0);
    expectVal("pcSrc", pcSrc, 1'b0); // cmp never writes
  endtask

  // ldmia r0{!}, {r1, r2}
  function automatic logic [31:0] ldmWord(input logic wBit);
    return {4'hE, 3'b100, 1'b0, 1'b1, 1'b0, wBit, 1'b1, 4'h0, 16'h0006};
  endfunction

  task automatic ldmSequence(input logic wBit, input int stallCycles);
    drive(ldmWord(wBit), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b1);
    expectVal("isArm", isArm, 1'b1);
    expectVal("regSrc", regSrc, 4'b0100);
    expectVal("fwd", fwd, 2'b00);
    repeat (stallCycles) begin
      drive(ldmWord(wBit), 1'b1, 1'b1, 1'b0);
      expectVal("stallF", stallF, 1'b1);
      expectVal("regSrc", regSrc, 4'b0100);
      expectVal("fwd", fwd, 2'b01);
    end
    drive(ldmWord(wBit), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b0);
    expectVal("regWrite", regWrite, wBit);
    expectVal("regSrc", regSrc, 4'b1000);
    expectVal("fwd", fwd, 2'b01);
  endtask

  task automatic armLdm();
    ldmSequence(1'b1, 3);
    ldmSequence(1'b0, 1);
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b1);
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b1); // flushed while in rest
    expectVal("stallF", stallF, 1'b0);
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b0);   // step held in rest
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b1); // flushed while in first
    expectVal("stallF", stallF, 1'b1);
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b1);   // step held in first
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b0);
    // reset in the middle of an LDM
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    @(negedge clk);
    rstN  = 1'b0;
    instr = 32'h00500093;
    #20;
    expectVal("stallF", stallF, 1'b0);
    expectVal("isArm", isArm, 1'b0);
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b1);   // reset put the step back to first
    drive(ldmWord(1'b1), 1'b1, 1'b0, 1'b0);
    expectVal("stallF", stallF, 1'b0);
  endtask

  initial begin
    rstN       = 1'b0;
    instr      = 32'h00000013; // addi x0, x0, 0
    notFlushed = 1'b1;
    flushE     = 1'b0;
    ldmStall   = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    rvAluWords();
    rvMemAndFlow();
    isaSelection();
    armDataProcessing();
    armLdm();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* all.f */
isaPkg.sv
rvDecoder.sv
armDecoder.sv
immExtend.sv
decodeControl.sv
decodeStage.sv
tbDecodeStage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - isaPkg.sv
  - rvDecoder.sv
  - armDecoder.sv
  - immExtend.sv
  - decodeControl.sv
  - decodeStage.sv
  - target: test
    files:
      - tbDecodeStage.sv
